// ==== bench/program_input.hex ====
// line 1: instruction count, expected commit count; then one instruction word per line
// then one expected commit per line: kind (1 register, 2 store), rd or address, value or data
0000000e 0000000d
10000093 // addi x1, x0, 0x100
ffd00113 // addi x2, x0, -3
0020a423 // sw   x2, 8(x1)
002081b3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
003272b3 // and  x5, x4, x3
0012e333 // or   x6, x5, x1
004343b3 // xor  x7, x6, x4
00322433 // slt  x8, x4, x3
00c38013 // addi x0, x7, 12
008004b3 // add  x9, x0, x8
0021a533 // slt  x10, x3, x2
fe732e23 // sw   x7, -4(x6)
fff48593 // addi x11, x9, -1
00000001 00000001 00000100
00000001 00000002 fffffffd
00000002 00000108 fffffffd
00000001 00000003 000000fd
00000001 00000004 fffffffd
00000001 00000005 000000fd
00000001 00000006 000001fd
00000001 00000007 fffffe00
00000001 00000008 00000001
00000001 00000009 00000001
00000001 0000000a 00000000
00000002 000001f9 fffffe00
00000001 0000000b 00000000

// ==== verilog.f ====
common/rv32_pkg.sv
common/rob_pkg.sv
hw/dispatch_decoder.sv
hw/alu_unit.sv
reorder_buffer/reorder_buffer.sv
hw/reg_file.sv
hw/ooo_core_top.sv
bench/clk_gen.sv
bench/ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - common/rv32_pkg.sv
  - common/rob_pkg.sv
  - hw/dispatch_decoder.sv
  - hw/alu_unit.sv
  - reorder_buffer/reorder_buffer.sv
  - hw/reg_file.sv
  - hw/ooo_core_top.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/ooo_core_tb.sv

// ==== bench/ooo_core_tb.sv ====
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int          stim_words = 128;
    localparam int          kind_reg   = 1;
    localparam int          kind_st    = 2;
    localparam logic [31:0] rand_seed  = 32'hb9b4;
    // first store is held long enough for the reorder buffer to fill
    localparam int          slow_extra = 60;

    logic        clk;
    logic        rst;
    logic        in_req;
    logic [31:0] in_instr;
    logic        in_ack;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_val;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_resp;

    logic [31:0] stim [stim_words];
    int          src_seed;
    int          mem_seed;
    int          n_instr;
    int          n_exp;
    int          exp_base;
    int          exp_idx       = 0;
    int          mismatches    = 0;
    int          other_errs    = 0;
    int          commits_seen  = 0;
    int          stall_cycles  = 0;
    int          cycle_count   = 0;
    int          cycle_limit   = 0;
    logic        prev_ack      = 1'b0;
    logic        prev_write    = 1'b0;
    logic [31:0] held_addr;
    logic [31:0] held_data;

    clk_gen clk_gen_i (
        .clk, .rst
    );

    ooo_core_top #(
        .rob_depth(8)
    ) dut_i (
        .clk, .rst, .in_req, .in_instr, .in_ack,
        .commit_valid, .commit_rd, .commit_val,
        .mem_write, .mem_addr, .mem_wdata, .mem_resp
    );

    // column 0 is the kind, 1 is rd or address and 2 is value or data
    function automatic logic [31:0] expected_field(int idx, int col);
        return stim[exp_base + 3 * idx + col];
    endfunction

    task automatic check_idle_outputs();
        assert (!in_ack && !commit_valid && !mem_write) else begin
            other_errs++;
            $display("outputs not idle around reset: in_ack %b commit_valid %b mem_write %b",
                     in_ack, commit_valid, mem_write);
        end
    endtask

    // one full four-phase transfer followed by a random idle gap
    task automatic send_instr(logic [31:0] word);
        int gap;
        @(posedge clk);
        #1;
        in_instr = word;
        in_req   = 1'b1;
        do @(negedge clk); while (!in_ack);
        @(posedge clk);
        #1 in_req = 1'b0;
        do @(negedge clk); while (in_ack);
        gap = {$random(src_seed)} % 4;
        repeat (gap) @(posedge clk);
    endtask

    task automatic close_run();
        $display("errors: %0d mismatches, %0d other; commits seen %0d of %0d",
                 mismatches, other_errs, commits_seen, n_exp);
        if (mismatches == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // protocol and result checks on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            // four-phase order on the instruction port
            if (in_ack && !prev_ack) begin
                assert (in_req) else begin
                    other_errs++;
                    $display("in_ack rose while in_req was low at %0t", $time);
                end
            end
            if (!in_ack && prev_ack) begin
                assert (!in_req) else begin
                    other_errs++;
                    $display("in_ack fell before in_req was dropped at %0t", $time);
                end
            end
            // request held back by a full buffer
            if (in_req && !in_ack && !dut_i.alloc_free) begin
                stall_cycles++;
            end
            if (commit_valid) begin
                commits_seen++;
                assert (commit_rd != 5'd0) else begin
                    other_errs++;
                    $display("commit_valid raised for a write to x0");
                end
                assert (exp_idx < n_exp) else begin
                    other_errs++;
                    $display("register commit beyond the end of the expected stream");
                end
                if (exp_idx < n_exp) begin
                    assert (expected_field(exp_idx, 0) == kind_reg) else begin
                        other_errs++;
                        $display("register commit where a store was expected");
                    end
                    assert (commit_rd == expected_field(exp_idx, 1)) else begin
                        mismatches++;
                        $display("MISMATCH commit_rd: got %h, expected %h",
                                 commit_rd, expected_field(exp_idx, 1));
                    end
                    assert (commit_val == expected_field(exp_idx, 2)) else begin
                        mismatches++;
                        $display("MISMATCH commit_val: got %h, expected %h",
                                 commit_val, expected_field(exp_idx, 2));
                    end
                    exp_idx++;
                end
            end
            if (mem_write && !prev_write) begin
                // a new store is compared once against the stream
                commits_seen++;
                held_addr = mem_addr;
                held_data = mem_wdata;
                assert (exp_idx < n_exp) else begin
                    other_errs++;
                    $display("store beyond the end of the expected stream");
                end
                if (exp_idx < n_exp) begin
                    assert (expected_field(exp_idx, 0) == kind_st) else begin
                        other_errs++;
                        $display("store where a register commit was expected");
                    end
                    assert (mem_addr == expected_field(exp_idx, 1)) else begin
                        mismatches++;
                        $display("MISMATCH mem_addr: got %h, expected %h",
                                 mem_addr, expected_field(exp_idx, 1));
                    end
                    assert (mem_wdata == expected_field(exp_idx, 2)) else begin
                        mismatches++;
                        $display("MISMATCH mem_wdata: got %h, expected %h",
                                 mem_wdata, expected_field(exp_idx, 2));
                    end
                    exp_idx++;
                end
            end else if (mem_write) begin
                assert (mem_addr == held_addr && mem_wdata == held_data) else begin
                    other_errs++;
                    $display("store address or data changed before mem_resp at %0t", $time);
                end
            end
        end
        prev_ack   = in_ack;
        prev_write = mem_write;
    end

    // memory responder gives one pulse of mem_resp per store
    initial begin
        int delay;
        int answered;
        answered = 0;
        forever begin
            @(negedge clk);
            if (mem_write && !rst) begin
                delay = {$random(mem_seed)} % 7;
                if (answered == 0) begin
                    delay += slow_extra;
                end
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1 mem_resp = 1'b1;
                @(posedge clk);
                #1 mem_resp = 1'b0;
                answered++;
            end
        end
    end

    // cycle limit scaled by program length
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        other_errs++;
        $display("timeout after %0d cycles, %0d of %0d commits seen",
                 cycle_count, commits_seen, n_exp);
        close_run();
    end

    initial begin
        src_seed = rand_seed;
        mem_seed = rand_seed;
        in_req   = 1'b0;
        in_instr = '0;
        mem_resp = 1'b0;
        $readmemh("bench/program_input.hex", stim);
        n_instr     = stim[0];
        n_exp       = stim[1];
        exp_base    = 2 + n_instr;
        cycle_limit = 40 * n_instr + 100;
        // still inside reset here
        repeat (2) @(negedge clk);
        check_idle_outputs();
        wait (!rst);
        @(negedge clk);
        check_idle_outputs();
        for (int i = 0; i < n_instr; i++) begin
            send_instr(stim[2 + i]);
        end
        while (exp_idx < n_exp) @(negedge clk);
        // a few more cycles so a stray commit would still be seen
        repeat (5) @(negedge clk);
        assert (commits_seen == n_exp) else begin
            other_errs++;
            $display("saw %0d commits, expected %0d", commits_seen, n_exp);
        end
        assert (stall_cycles > 0) else begin
            other_errs++;
            $display("buffer never filled while the first store was held");
        end
        close_run();
    end

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter real period       = 8.0,
    parameter int  reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #(period / 2.0) clk = ~clk;

    // reset drops 1 ns after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== hw/ooo_core_top.sv ====
`timescale 1ns/1ps

module ooo_core_top import rv32_pkg::*; import rob_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic     clk,
    input  logic     rst,
    // instruction port
    input  logic     in_req,
    input  rv32_word in_instr,
    output logic     in_ack,
    // commit stream
    output logic     commit_valid,
    output rv32_reg  commit_rd,
    output rv32_word commit_val,
    // store port
    output logic     mem_write,
    output rv32_word mem_addr,
    output rv32_word mem_wdata,
    input  logic     mem_resp
);

    // allocation
    logic      alloc_free;
    tag_t      alloc_tag;
    logic      alloc_valid;
    rob_kind_e alloc_kind;
    rv32_reg   alloc_dest;
    // register read and rename
    rv32_reg   rs1_idx;
    rv32_reg   rs2_idx;
    rv32_word  rs1_val;
    tag_t      rs1_tag;
    rv32_word  rs2_val;
    tag_t      rs2_tag;
    logic      rename_valid;
    rv32_reg   rename_rd;
    tag_t      rename_tag;
    // forwarding
    tag_t      fwd1_tag;
    tag_t      fwd2_tag;
    logic      fwd1_ready;
    rv32_word  fwd1_val;
    logic      fwd2_ready;
    rv32_word  fwd2_val;
    // issue
    logic      iss_valid;
    alu_op_e   iss_op;
    rv32_word  iss_a;
    rv32_word  iss_b;
    rv32_word  iss_store_data;
    logic      iss_is_store;
    tag_t      iss_tag;
    // result bus
    logic                  cdb_valid;
    tag_t                  cdb_tag;
    logic [cdb_val_w-1:0]  cdb_val;
    logic [cdb_addr_w-1:0] cdb_addr;
    // commit tag only goes to the register file
    tag_t      commit_tag;

    dispatch_decoder dispatch_decoder_i (
        .clk, .rst, .in_req, .in_instr, .in_ack,
        .alloc_free, .alloc_tag, .alloc_valid, .alloc_kind, .alloc_dest,
        .rs1_idx, .rs2_idx, .rs1_val, .rs1_tag, .rs2_val, .rs2_tag,
        .fwd1_tag, .fwd2_tag, .fwd1_ready, .fwd1_val, .fwd2_ready, .fwd2_val,
        .rename_valid, .rename_rd, .rename_tag,
        .iss_valid, .iss_op, .iss_a, .iss_b, .iss_store_data, .iss_is_store, .iss_tag
    );

    alu_unit alu_unit_i (
        .clk, .rst,
        .iss_valid, .iss_op, .iss_a, .iss_b, .iss_store_data, .iss_is_store, .iss_tag,
        .cdb_valid, .cdb_tag, .cdb_val, .cdb_addr
    );

    reorder_buffer #(
        .rob_depth(rob_depth)
    ) reorder_buffer_i (
        .clk, .rst,
        .alloc_valid, .alloc_kind, .alloc_dest, .alloc_free, .alloc_tag,
        .cdb_valid, .cdb_tag, .cdb_val, .cdb_addr,
        .fwd1_tag, .fwd2_tag, .fwd1_ready, .fwd1_val, .fwd2_ready, .fwd2_val,
        .commit_valid, .commit_rd, .commit_val, .commit_tag,
        .mem_write, .mem_addr, .mem_wdata, .mem_resp
    );

    reg_file reg_file_i (
        .clk, .rst,
        .rs1_idx, .rs2_idx, .rs1_val, .rs1_tag, .rs2_val, .rs2_tag,
        .rename_valid, .rename_rd, .rename_tag,
        .commit_valid, .commit_rd, .commit_val, .commit_tag
    );

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv32_pkg::*; import rob_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // combinational read ports
    input  rv32_reg  rs1_idx,
    input  rv32_reg  rs2_idx,
    output rv32_word rs1_val,
    output tag_t     rs1_tag,
    output rv32_word rs2_val,
    output tag_t     rs2_tag,
    // mark a register as pending
    input  logic     rename_valid,
    input  rv32_reg  rename_rd,
    input  tag_t     rename_tag,
    // in-order commit from the reorder buffer
    input  logic     commit_valid,
    input  rv32_reg  commit_rd,
    input  rv32_word commit_val,
    input  tag_t     commit_tag
);

    rv32_word regs [32];
    // producer tag per register, 0 when the value here is current
    tag_t     tags [32];

    // x0 is hardwired to zero and never pending
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs1_tag = (rs1_idx == '0) ? no_tag : tags[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];
    assign rs2_tag = (rs2_idx == '0) ? no_tag : tags[rs2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            // architectural state starts at zero
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                tags[i] <= no_tag;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                regs[commit_rd] <= commit_val;
                // only clear if no younger producer took over
                if (tags[commit_rd] == commit_tag) begin
                    tags[commit_rd] <= no_tag;
                end
            end
            // later assignment, so a same-cycle rename wins
            if (rename_valid && rename_rd != '0) begin
                tags[rename_rd] <= rename_tag;
            end
        end
    end

endmodule

// ==== reorder_buffer/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer import rv32_pkg::*; import rob_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    // allocation from the decoder
    input  logic                  alloc_valid,
    input  rob_kind_e             alloc_kind,
    input  rv32_reg               alloc_dest,
    output logic                  alloc_free,
    output tag_t                  alloc_tag,
    // common result bus
    input  logic                  cdb_valid,
    input  tag_t                  cdb_tag,
    input  logic [cdb_val_w-1:0]  cdb_val,
    input  logic [cdb_addr_w-1:0] cdb_addr,
    // forwarding to the decoder
    input  tag_t                  fwd1_tag,
    input  tag_t                  fwd2_tag,
    output logic                  fwd1_ready,
    output rv32_word              fwd1_val,
    output logic                  fwd2_ready,
    output rv32_word              fwd2_val,
    // register commit
    output logic                  commit_valid,
    output rv32_reg               commit_rd,
    output rv32_word              commit_val,
    output tag_t                  commit_tag,
    // store port
    output logic                  mem_write,
    output rv32_word              mem_addr,
    output rv32_word              mem_wdata,
    input  logic                  mem_resp
);

    localparam logic st_idle = 1'b0;
    localparam logic st_wait = 1'b1;

    // entry 0 stays unused so that tag 0 can mean "no producer"
    logic      rob_busy  [rob_depth+1];
    rob_kind_e rob_kind  [rob_depth+1];
    // rd for register entries, address for stores
    rv32_word  rob_dest  [rob_depth+1];
    // result value, or store data
    rv32_word  rob_val   [rob_depth+1];
    logic      rob_ready [rob_depth+1];

    tag_t in_head;
    tag_t commit_head;
    logic st_state;
    logic head_ready;
    logic reg_take;
    logic head_retire;

    // step a head pointer, wrapping from rob_depth back to 1
    function automatic tag_t next_ptr(tag_t p);
        next_ptr = (p == tag_t'(rob_depth)) ? tag_t'(1) : tag_t'(p + 1'b1);
    endfunction

    assign alloc_free = !rob_busy[in_head];
    assign alloc_tag  = in_head;

    // forwarding, the bus wins over the stored copy
    assign fwd1_ready = (cdb_valid && cdb_tag == fwd1_tag) || rob_ready[fwd1_tag];
    assign fwd1_val   = (cdb_valid && cdb_tag == fwd1_tag) ? cdb_val : rob_val[fwd1_tag];
    assign fwd2_ready = (cdb_valid && cdb_tag == fwd2_tag) || rob_ready[fwd2_tag];
    assign fwd2_val   = (cdb_valid && cdb_tag == fwd2_tag) ? cdb_val : rob_val[fwd2_tag];

    assign head_ready = rob_busy[commit_head] && rob_ready[commit_head];
    // register entries retire in the cycle they are ready at the head
    assign reg_take   = head_ready && (rob_kind[commit_head] == REG);
    // stores retire only once memory has answered
    assign head_retire = reg_take || (st_state == st_wait && mem_resp);

    // x0 results are dropped without a visible commit
    assign commit_valid = reg_take && (rob_dest[commit_head][4:0] != '0);
    assign commit_rd    = rob_dest[commit_head][4:0];
    assign commit_val   = rob_val[commit_head];
    assign commit_tag   = commit_head;

    // memory port holds the head entry while waiting
    assign mem_write = (st_state == st_wait);
    assign mem_addr  = rob_dest[commit_head];
    assign mem_wdata = rob_val[commit_head];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i <= rob_depth; i++) begin
                rob_busy[i]  <= 1'b0;
                rob_ready[i] <= 1'b0;
            end
            in_head     <= tag_t'(1);
            commit_head <= tag_t'(1);
            st_state    <= st_idle;
        end else begin
            // new entry at the input head
            if (alloc_valid) begin
                rob_busy[in_head]  <= 1'b1;
                rob_kind[in_head]  <= alloc_kind;
                rob_dest[in_head]  <= rv32_word'(alloc_dest);
                rob_ready[in_head] <= 1'b0;
                in_head            <= next_ptr(in_head);
            end
            // capture a result from the bus
            if (cdb_valid) begin
                rob_val[cdb_tag]   <= cdb_val;
                rob_ready[cdb_tag] <= 1'b1;
                if (rob_kind[cdb_tag] == ST) begin
                    rob_dest[cdb_tag] <= cdb_addr;
                end
            end
            // free the head entry and move on
            if (head_retire) begin
                rob_busy[commit_head]  <= 1'b0;
                rob_ready[commit_head] <= 1'b0;
                commit_head            <= next_ptr(commit_head);
            end
            // store handshake
            case (st_state)
                st_idle: begin
                    if (head_ready && rob_kind[commit_head] == ST) begin
                        st_state <= st_wait;
                    end
                end
                st_wait: begin
                    if (mem_resp) begin
                        st_state <= st_idle;
                    end
                end
                default: st_state <= st_idle;
            endcase
        end
    end

endmodule

// ==== hw/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit import rv32_pkg::*; import rob_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // issue from the decoder
    input  logic                  iss_valid,
    input  alu_op_e               iss_op,
    input  rv32_word              iss_a,
    input  rv32_word              iss_b,
    input  rv32_word              iss_store_data,
    input  logic                  iss_is_store,
    input  tag_t                  iss_tag,
    // common result bus
    output logic                  cdb_valid,
    output tag_t                  cdb_tag,
    output logic [cdb_val_w-1:0]  cdb_val,
    output logic [cdb_addr_w-1:0] cdb_addr
);

    rv32_word sum;
    rv32_word result;

    // shared adder, also the store address
    assign sum = iss_a + iss_b;

    always_comb begin
        case (iss_op)
            alu_add: result = sum;
            alu_sub: result = iss_a - iss_b;
            alu_and: result = iss_a & iss_b;
            alu_or:  result = iss_a | iss_b;
            alu_xor: result = iss_a ^ iss_b;
            // signed compare, result is 0 or 1
            alu_slt: result = ($signed(iss_a) < $signed(iss_b)) ? 32'd1 : 32'd0;
            default: result = sum;
        endcase
    end

    // valid pulse one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag  <= iss_tag;
        // stores carry their data in the value field
        cdb_val  <= iss_is_store ? iss_store_data : result;
        cdb_addr <= iss_is_store ? sum : '0;
    end

endmodule

// ==== hw/dispatch_decoder.sv ====
`timescale 1ns/1ps

module dispatch_decoder import rv32_pkg::*; import rob_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // four-phase instruction port
    input  logic      in_req,
    input  rv32_word  in_instr,
    output logic      in_ack,
    // reorder buffer allocation
    input  logic      alloc_free,
    input  tag_t      alloc_tag,
    output logic      alloc_valid,
    output rob_kind_e alloc_kind,
    output rv32_reg   alloc_dest,
    // register file read
    output rv32_reg   rs1_idx,
    output rv32_reg   rs2_idx,
    input  rv32_word  rs1_val,
    input  tag_t      rs1_tag,
    input  rv32_word  rs2_val,
    input  tag_t      rs2_tag,
    // forwarding from in-flight producers
    output tag_t      fwd1_tag,
    output tag_t      fwd2_tag,
    input  logic      fwd1_ready,
    input  rv32_word  fwd1_val,
    input  logic      fwd2_ready,
    input  rv32_word  fwd2_val,
    // rename of the destination
    output logic      rename_valid,
    output rv32_reg   rename_rd,
    output tag_t      rename_tag,
    // issue to the alu
    output logic      iss_valid,
    output alu_op_e   iss_op,
    output rv32_word  iss_a,
    output rv32_word  iss_b,
    output rv32_word  iss_store_data,
    output logic      iss_is_store,
    output tag_t      iss_tag
);

    localparam logic hs_idle  = 1'b0;
    localparam logic hs_acked = 1'b1;

    logic        hs_state;
    rv32_instr_u word;
    logic        is_reg;
    logic        is_imm;
    logic        is_store;
    logic        legal;
    logic        op1_ok;
    logic        op2_ok;
    logic        fire;
    rv32_word    op1;
    rv32_word    op2;
    rv32_word    i_imm;
    rv32_word    s_imm;

    assign word     = in_instr;
    assign is_reg   = (word.ir.opcode == op_reg);
    assign is_imm   = (word.ir.opcode == op_imm);
    assign is_store = (word.s.opcode == op_store) && (word.s.funct3 == f3_sw);
    // anything else is acked and dropped
    assign legal    = is_reg || is_imm || is_store;

    // immediates, sign-extended from bit 31
    assign i_imm = {{20{word.ir.funct7[6]}}, word.ir.funct7, word.ir.rs2};
    assign s_imm = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};

    // operand lookup, tag 0 means the register file value is current
    assign rs1_idx  = word.ir.rs1;
    assign rs2_idx  = word.ir.rs2;
    assign fwd1_tag = rs1_tag;
    assign fwd2_tag = rs2_tag;
    assign op1      = (rs1_tag == no_tag) ? rs1_val : fwd1_val;
    assign op2      = (rs2_tag == no_tag) ? rs2_val : fwd2_val;
    assign op1_ok   = (rs1_tag == no_tag) || fwd1_ready;
    // i format has no rs2, those bits are immediate
    assign op2_ok   = is_imm || (rs2_tag == no_tag) || fwd2_ready;

    // one issue per request, only from idle
    assign fire = (hs_state == hs_idle) && in_req &&
                  (!legal || (alloc_free && op1_ok && op2_ok));

    assign in_ack = fire || (hs_state == hs_acked);

    always_comb begin
        iss_op = alu_add;
        if (!is_store) begin
            case (word.ir.funct3)
                f3_add_sub: iss_op = (is_reg && word.ir.funct7 == f7_sub) ? alu_sub : alu_add;
                f3_slt:     iss_op = alu_slt;
                f3_xor:     iss_op = alu_xor;
                f3_or:      iss_op = alu_or;
                f3_and:     iss_op = alu_and;
                default:    iss_op = alu_add;
            endcase
        end
    end

    assign alloc_valid = fire && legal;
    assign alloc_kind  = is_store ? ST : REG;
    assign alloc_dest  = is_store ? '0 : word.ir.rd;

    // x0 never gets a producer
    assign rename_valid = fire && legal && !is_store && (word.ir.rd != '0);
    assign rename_rd    = word.ir.rd;
    assign rename_tag   = alloc_tag;

    assign iss_valid      = fire && legal;
    assign iss_a          = op1;
    // second operand is rs2 for r format, otherwise the immediate
    assign iss_b          = is_reg ? op2 : (is_store ? s_imm : i_imm);
    assign iss_store_data = op2;
    assign iss_is_store   = is_store;
    assign iss_tag        = alloc_tag;

    // hold ack until the source drops its request
    always_ff @(posedge clk) begin
        if (rst) begin
            hs_state <= hs_idle;
        end else begin
            case (hs_state)
                hs_idle:  if (fire) hs_state <= hs_acked;
                hs_acked: if (!in_req) hs_state <= hs_idle;
                default:  hs_state <= hs_idle;
            endcase
        end
    end

endmodule

// ==== common/rob_pkg.sv ====
package rob_pkg;

    // tag width, tag 0 is reserved for "value is in the register file"
    localparam int TAG_W = 4;

    typedef logic [TAG_W-1:0] tag_t;

    localparam tag_t no_tag = '0;

    // what an entry does when it reaches the commit head
    typedef enum logic [1:0] {
        REG = 2'd0,
        ST  = 2'd1
    } rob_kind_e;

    // result bus payload
    // value carries alu result or store data
    localparam int cdb_val_w  = 32;
    // address is only meaningful for stores
    localparam int cdb_addr_w = 32;

endpackage

// ==== common/rv32_pkg.sv ====
package rv32_pkg;

    // basic data and register index types
    typedef logic [31:0] rv32_word;
    typedef logic [4:0]  rv32_reg;

    // major opcodes handled by the core
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_store = 7'b0100011;

    // funct3 encodings for the alu group
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    // word store, the only store width supported
    localparam logic [2:0] f3_sw      = 3'b010;

    // funct7 that turns add into sub
    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    // one instruction word, seen either as r/i format or as s format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            rv32_reg    rs2;
            rv32_reg    rs1;
            logic [2:0] funct3;
            rv32_reg    rd;
            logic [6:0] opcode;
        } ir;
        struct packed {
            logic [6:0] imm_hi;
            rv32_reg    rs2;
            rv32_reg    rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } rv32_instr_u;

endpackage
